//--- run_sim.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_fetch -f src.f -o tb_fetch_sim

# A failing run exits non-zero, the log is searched below
./obj_dir/tb_fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q -F '*** FAILED ***' sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q -F '*** PASSED ***' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation finished cleanly"

//--- sim/tb_fetch.sv
// --------------------
// Fetch unit testbench
// Table of redirects and stall rates, decode-side reference walk
// --------------------

`default_nettype none

module tb_fetch;

    timeunit 1ns;
    timeprecision 100ps;

    logic             g_clk;
    logic             g_resetn;
    logic             cf_req;
    fetch_pkg::addr_t cf_target;
    logic             cf_ack;
    logic             imem_req;
    fetch_pkg::addr_t imem_addr;
    logic             imem_gnt;
    fetch_pkg::word_t imem_rdata;
    logic             imem_error;
    logic             s1_busy;
    logic             s1_valid;
    fetch_pkg::word_t s1_data;
    logic             s1_error;
    logic             grant_en;     // Memory may grant this cycle

    // Test table
    // --------------------

    localparam int n_tests = 7;

    string test_name [n_tests] = '{"reset_stream", "redirect_word", "redirect_half",
                                   "redirect_half16", "redirect_inflight",
                                   "random_long", "error_region"};

    localparam logic row_jump [n_tests] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    localparam fetch_pkg::addr_t row_target [n_tests] = '{
        32'h0000_0000, 32'h8000_1000, 32'h8000_2002, 32'h8000_300a,
        32'h8000_4000, 32'h0000_0000, 32'h8000_0ee2};
    localparam int row_count [n_tests] = '{40, 30, 30, 30, 30, 200, 100};
    localparam int row_stall [n_tests] = '{0, 2, 2, 3, 6, 3, 2};   // Eighths without grant
    localparam int row_busy  [n_tests] = '{0, 1, 2, 1, 0, 3, 2};   // Eighths with busy

    fetch_pkg::addr_t ref_pc;       // Next expected instr address
    int               consumed;     // Instrs taken in this row
    int               cur_test;
    int               stall_rate;
    int               busy_rate;
    logic [15:0]      lfsr_state;
    logic             grant_seen;
    logic             redirect_done;

    fetch_unit #(
        .RESET_PC  (fetch_pkg::reset_pc_default),
        .BUF_DEPTH (fetch_pkg::buf_depth_default)
    ) u_dut (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .cf_req     (cf_req),
        .cf_target  (cf_target),
        .cf_ack     (cf_ack),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_gnt   (imem_gnt),
        .imem_rdata (imem_rdata),
        .imem_error (imem_error),
        .s1_busy    (s1_busy),
        .s1_valid   (s1_valid),
        .s1_data    (s1_data),
        .s1_error   (s1_error)
    );

    tb_fetch_mem u_mem (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .grant_en   (grant_en),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_gnt   (imem_gnt),
        .imem_rdata (imem_rdata),
        .imem_error (imem_error)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;      // 4 ns period
    end

    // Helpers
    // --------------------

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input fetch_pkg::word_t exp,
                              input fetch_pkg::word_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    // Galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
        end
    endtask

    // One clock: sample at the edge, check, then drive the next inputs
    task automatic run_cycle();
        int               rnd;
        fetch_pkg::half_t lo_half;
        fetch_pkg::half_t hi_half;
        fetch_pkg::addr_t hi_pc;
        logic             long_instr;
        fetch_pkg::word_t exp_data;
        fetch_pkg::word_t got_data;
        logic             exp_err;
        @(posedge g_clk);
        check_bit($sformatf("%s cf_ack", test_name[cur_test]),
                  !(imem_req && !imem_gnt), cf_ack);
        grant_seen = imem_req && imem_gnt;

        // Consumed instr against the reference walk
        if (s1_valid && !s1_busy) begin
            hi_pc      = ref_pc + 32'd2;
            lo_half    = u_mem.parcel_at(ref_pc);
            hi_half    = u_mem.parcel_at(hi_pc);
            long_instr = lo_half[1:0] == 2'b11;
            exp_data   = long_instr ? {hi_half, lo_half} : {16'h0000, lo_half};
            got_data   = s1_data;           // Upper half must be zero for a short instr
            exp_err    = u_mem.word_has_error({ref_pc[31:2], 2'b00}) ||
                         (long_instr && u_mem.word_has_error({hi_pc[31:2], 2'b00}));
            check_word($sformatf("%s data at %h", test_name[cur_test], ref_pc),
                       exp_data, got_data);
            check_bit($sformatf("%s error at %h", test_name[cur_test], ref_pc),
                      exp_err, s1_error);
            ref_pc   = ref_pc + (long_instr ? 32'd4 : 32'd2);
            consumed = consumed + 1;
        end

        // Redirect taken on this edge, after any old-stream consume
        if (cf_req && cf_ack) begin
            cf_req        <= 1'b0;
            ref_pc        = cf_target;
            consumed      = 0;
            redirect_done = 1'b1;
        end

        random_bits(3, rnd);
        grant_en <= (rnd >= stall_rate);
        random_bits(3, rnd);
        s1_busy  <= (rnd < busy_rate);
    endtask

    task automatic apply_test(input int t);
        cur_test   = t;
        stall_rate = row_stall[t];
        busy_rate  = row_busy[t];
        consumed   = 0;
        if (row_jump[t]) begin
            // Raise the redirect while a response is on the bus
            grant_seen = 1'b0;
            while (!grant_seen) begin
                run_cycle();
            end
            cf_target     <= row_target[t];
            cf_req        <= 1'b1;
            redirect_done = 1'b0;
            while (!redirect_done) begin
                run_cycle();
            end
        end
        while (consumed < row_count[t]) begin
            run_cycle();
        end
    endtask

    // Main sequence
    // --------------------

    initial begin
        g_resetn   = 1'b0;
        cf_req     = 1'b0;
        cf_target  = '0;
        s1_busy    = 1'b0;
        grant_en   = 1'b0;
        lfsr_state = 16'd61;
        ref_pc     = fetch_pkg::reset_pc_default;
        cur_test   = 0;

        repeat (8) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(posedge g_clk);                   // First edge out of reset
        check_bit("reset imem_req", 1'b0, imem_req);
        check_bit("reset s1_valid", 1'b0, s1_valid);
        @(posedge g_clk);
        check_bit("reset first request", 1'b1, imem_req);
        check_word("reset first address", fetch_pkg::reset_pc_default, imem_addr);

        for (int t = 0; t < n_tests; t++) begin
            apply_test(t);
        end

        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog, 40 cycles per instr of the whole table
    initial begin
        int limit;
        limit = 0;
        for (int t = 0; t < n_tests; t++) begin
            limit = limit + row_count[t] * 40 * 4;
        end
        #(limit);
        $display("Watchdog expired after %0d ns in test %s", limit, test_name[cur_test]);
        stop_with_failure();
    end

endmodule

`default_nettype wire

//--- sim/tb_fetch_mem.sv
// --------------------
// Instruction memory model for the fetch testbench
// Grants a pending request when the testbench allows it
// and answers one cycle later with address-derived data
// --------------------

`default_nettype none

module tb_fetch_mem (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              grant_en,     // Random grant slot
    input  logic              imem_req,
    input  fetch_pkg::addr_t  imem_addr,
    output logic              imem_gnt,
    output fetch_pkg::word_t  imem_rdata,
    output logic              imem_error
);

    timeunit 1ns;
    timeprecision 100ps;

    // Memory contents
    // --------------------

    // Parcel at byte address b, low bits pick the instr length
    function automatic fetch_pkg::half_t parcel_at(input fetch_pkg::addr_t b);
        logic [1:0] low;
        if ((b[3:1] == 3'd1) || (b[3:1] == 3'd4)) begin
            low = 2'b11;                    // Start of a 32-bit instr
        end else begin
            low = b[2:1];                   // 11 here as well for offsets 6 and 14
        end
        return {b[15:2], low};
    endfunction

    function automatic fetch_pkg::word_t word_at(input fetch_pkg::addr_t a);
        return {parcel_at(a + 32'd2), parcel_at(a)};  // Little endian parcels
    endfunction

    // Bus error region, one in every 4 KiB
    function automatic logic word_has_error(input fetch_pkg::addr_t a);
        return a[11:8] == 4'hf;
    endfunction

    // Bus side
    // --------------------

    logic             rsp_valid = 1'b0;    // Response on the bus this cycle
    fetch_pkg::word_t rsp_data;
    logic             rsp_err;

    assign imem_gnt = imem_req && grant_en;

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= imem_req && imem_gnt;
            if (imem_req && imem_gnt) begin
                rsp_data <= word_at(imem_addr);
                rsp_err  <= word_has_error(imem_addr);
            end
        end
    end

    // Zero data and a raised error outside response cycles
    assign imem_rdata = rsp_valid ? rsp_data : 32'h0000_0000;
    assign imem_error = rsp_valid ? rsp_err  : 1'b1;

endmodule

`default_nettype wire

//--- source/fetch_buffer.sv
// --------------------
// Fetch buffer
// Halfword shift queue between the memory bus and decode
// Aligns 16/32-bit instructions across word boundaries
// --------------------

`default_nettype none

module fetch_buffer #(
    parameter int BUF_DEPTH = fetch_pkg::buf_depth_default
) (
    input  logic               g_clk,        // Clock
    input  logic               g_resetn,     // Sync reset, active low
    input  logic               flush,        // Drop all entries

    input  logic               store_word,   // Append both halfwords
    input  logic               store_upper,  // Append upper halfword only
    input  fetch_pkg::word_t   in_data,      // Response word
    input  logic               in_error,     // Response error flag

    output fetch_pkg::depth_t  depth,        // Current occupancy
    output fetch_pkg::depth_t  next_depth,   // Occupancy after this cycle

    output logic               instr_is_16,  // Head is a compressed instr
    output logic               instr_is_32,  // Head is a full-width instr

    input  logic               s1_busy,      // Decode stall
    output logic               s1_valid,     // Head instruction complete
    output fetch_pkg::word_t   s1_data,      // Head instruction
    output logic               s1_error      // Error on any used halfword
);

    // Storage
    // --------------------

    fetch_pkg::half_t  data_q [BUF_DEPTH];      // Entry 0 is the head
    logic [BUF_DEPTH-1:0] err_q;                 // Per-entry bus error
    fetch_pkg::depth_t depth_q;                  // Valid entries

    // Next-state entries
    fetch_pkg::half_t  data_d [BUF_DEPTH];
    logic [BUF_DEPTH-1:0] err_d;

    // Queue padded with two empty slots so a shift never reads past the end
    fetch_pkg::half_t  pad_data [BUF_DEPTH+2];
    logic [BUF_DEPTH+1:0] pad_err;

    logic              head_long;   // Head low bits are 11
    logic              consume;     // Decode takes the head this cycle
    logic [1:0]        cons_n;      // Halfwords leaving
    logic [1:0]        add_n;       // Halfwords arriving
    fetch_pkg::depth_t base;        // Depth after the consume

    // Head decode
    // --------------------

    assign head_long   = data_q[0][1:0] == 2'b11;
    assign instr_is_16 = (depth_q != '0) && !head_long;
    assign instr_is_32 = (depth_q != '0) &&  head_long;

    // Complete once both parcels of a long instruction are held
    assign s1_valid = instr_is_16 || (instr_is_32 && (depth_q >= 3'd2));

    // Upper half zeroed for a compressed instr
    assign s1_data  = instr_is_32 ? {data_q[1], data_q[0]}
                                  : {16'h0000, data_q[0]};

    assign s1_error = err_q[0] || (instr_is_32 && err_q[1]);

    // Occupancy
    // --------------------

    assign consume = s1_valid && !s1_busy;

    assign cons_n = !consume    ? 2'd0 :
                    instr_is_32 ? 2'd2 : 2'd1;

    assign add_n  = store_word  ? 2'd2 :
                    store_upper ? 2'd1 : 2'd0;

    assign base   = depth_q - {1'b0, cons_n};

    // Flush wins over any store in the same cycle
    assign next_depth = flush ? '0 : base + {1'b0, add_n};

    assign depth = depth_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            depth_q <= '0;
        end else begin
            depth_q <= next_depth;
        end
    end

    // Shift and append
    // --------------------

    always_comb begin
        for (int i = 0; i < BUF_DEPTH; i++) begin
            pad_data[i] = data_q[i];
            pad_err[i]  = err_q[i];
        end
        pad_data[BUF_DEPTH]   = '0;         // Empty tail slots
        pad_data[BUF_DEPTH+1] = '0;
        pad_err[BUF_DEPTH]    = 1'b0;
        pad_err[BUF_DEPTH+1]  = 1'b0;
    end

    always_comb begin
        for (int i = 0; i < BUF_DEPTH; i++) begin
            // Move the remaining entries toward the head
            data_d[i] = pad_data[i + int'(cons_n)];
            err_d[i]  = pad_err[i + int'(cons_n)];

            // New parcels land right behind what is left
            if (store_word && (i == int'(base))) begin
                data_d[i] = in_data[15:0];
                err_d[i]  = in_error;
            end
            if (store_word && (i == int'(base) + 1)) begin
                data_d[i] = in_data[31:16];
                err_d[i]  = in_error;
            end
            if (store_upper && (i == int'(base))) begin
                data_d[i] = in_data[31:16];     // Misaligned target
                err_d[i]  = in_error;
            end
        end
    end

    // Entries carry no reset, depth marks what is valid
    always_ff @(posedge g_clk) begin
        for (int i = 0; i < BUF_DEPTH; i++) begin
            data_q[i] <= data_d[i];
        end
        err_q <= err_d;
    end

endmodule

`default_nettype wire

//--- source/fetch_control.sv
// --------------------
// Fetch control
// Fetch address, memory requests and redirect acceptance
// Tracks misaligned targets and responses of the old stream
// --------------------

`default_nettype none

module fetch_control #(
    parameter fetch_pkg::addr_t RESET_PC  = fetch_pkg::reset_pc_default,
    parameter int               BUF_DEPTH = fetch_pkg::buf_depth_default
) (
    input  logic               g_clk,           // Clock
    input  logic               g_resetn,        // Sync reset, active low

    input  logic               cf_req,          // Redirect request
    input  fetch_pkg::addr_t   cf_target,       // Redirect target
    output logic               cf_ack,          // Redirect accepted

    output logic               imem_req,        // Bus request
    output fetch_pkg::addr_t   imem_addr,       // Word address
    input  logic               imem_gnt,        // Request taken
    input  fetch_pkg::word_t   imem_rdata,      // Response data
    input  logic               imem_error,      // Response error

    input  fetch_pkg::depth_t  buf_depth,       // Current occupancy
    input  fetch_pkg::depth_t  buf_next_depth,  // Occupancy after this cycle

    output logic               flush,           // Empty the buffer
    output logic               store_word,      // Store full response
    output logic               store_upper,     // Store upper half only
    output fetch_pkg::word_t   in_data,         // Data to buffer
    output logic               in_error         // Error to buffer
);

    // Room for one more word once the projected depth is at or below this
    localparam logic [3:0] req_limit = 4'(BUF_DEPTH - 2);

    logic       e_cf_change;     // Redirect taken this cycle
    logic       e_new_req;       // Request granted this cycle
    logic       rsp_pending;     // Response on the bus this cycle
    logic       drop_rsp;        // Response belongs to the old stream
    logic       misaligned;      // Next word holds only the upper parcel
    logic [3:0] proj_depth;      // Depth once granted data has landed
    logic       starved;         // Nothing held and nothing in flight
    logic       n_imem_req;

    // Events
    // --------------------

    // Only when no request waits for a grant
    assign cf_ack      = !imem_req || imem_gnt;
    assign e_cf_change = cf_req && cf_ack;
    assign e_new_req   = imem_req && imem_gnt;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_pending <= 1'b0;
            drop_rsp    <= 1'b0;
        end else begin
            rsp_pending <= e_new_req;
            drop_rsp    <= e_cf_change;  // Grant of this cycle is stale
        end
    end

    // Request planning
    // --------------------

    // A word granted now lands next cycle unless it is about to be dropped
    assign proj_depth = {1'b0, buf_next_depth} +
                        ((e_new_req && !e_cf_change) ? 4'd2 : 4'd0);

    assign starved    = (buf_depth == '0) && !rsp_pending;

    assign n_imem_req = (proj_depth <= req_limit) || starved;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req <= 1'b0;
        end else if (imem_req && !imem_gnt) begin
            imem_req <= 1'b1;            // Hold until granted
        end else begin
            imem_req <= n_imem_req;
        end
    end

    // Fetch address
    // --------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_addr <= {RESET_PC[31:2], 2'b00};
        end else if (e_cf_change) begin
            imem_addr <= {cf_target[31:2], 2'b00};   // Word aligned always
        end else if (e_new_req) begin
            imem_addr <= imem_addr + 32'd4;
        end
    end

    // Misalignment
    // --------------------

    // Set by a halfword target, cleared by the first upper-only store
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            misaligned <= RESET_PC[1];
        end else if (e_cf_change) begin
            misaligned <= cf_target[1];
        end else if (store_upper) begin
            misaligned <= 1'b0;
        end
    end

    // Buffer writes
    // --------------------

    assign flush       = e_cf_change;
    assign store_word  = rsp_pending && !misaligned && !drop_rsp;
    assign store_upper = rsp_pending &&  misaligned && !drop_rsp;

    assign in_data     = imem_rdata;     // Valid in the response cycle
    assign in_error    = imem_error;

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
// --------------------
// Fetch unit shared definitions
// Widths, payload types and default parameter values
// used by the fetch control, buffer and top level
// --------------------

`default_nettype none

package fetch_pkg;

    // Widths
    // --------------------

    localparam int xlen = 32;             // RV32 address and data width

    typedef logic [xlen-1:0] addr_t;      // Instruction address
    typedef logic [xlen-1:0] word_t;      // Memory data word
    typedef logic [15:0]     half_t;      // One instruction parcel
    typedef logic [2:0]      depth_t;     // Buffer occupancy in halfwords

    // Defaults
    // --------------------

    // First fetch address out of reset
    localparam addr_t reset_pc_default = 32'h8000_0000;

    // Buffer depth in halfwords, legal range 4 to 7
    localparam int buf_depth_default = 6;

endpackage

`default_nettype wire

//--- source/fetch_unit.sv
// --------------------
// Instruction fetch unit
// Word fetches into a halfword buffer for RV32 with compressed instrs
// --------------------

`default_nettype none

module fetch_unit #(
    parameter fetch_pkg::addr_t RESET_PC  = fetch_pkg::reset_pc_default,
    parameter int               BUF_DEPTH = fetch_pkg::buf_depth_default
) (
    input  logic               g_clk,
    input  logic               g_resetn,

    input  logic               cf_req,       // Redirect port
    input  fetch_pkg::addr_t   cf_target,
    output logic               cf_ack,

    output logic               imem_req,     // Instruction memory bus
    output fetch_pkg::addr_t   imem_addr,
    input  logic               imem_gnt,
    input  fetch_pkg::word_t   imem_rdata,
    input  logic               imem_error,

    input  logic               s1_busy,      // Decode port
    output logic               s1_valid,
    output fetch_pkg::word_t   s1_data,
    output logic               s1_error
);

    logic              flush;
    logic              store_word;
    logic              store_upper;
    fetch_pkg::word_t  in_data;
    logic              in_error;
    fetch_pkg::depth_t buf_depth;
    fetch_pkg::depth_t buf_next_depth;

    fetch_control #(
        .RESET_PC  (RESET_PC),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_control (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .cf_req         (cf_req),
        .cf_target      (cf_target),
        .cf_ack         (cf_ack),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .imem_gnt       (imem_gnt),
        .imem_rdata     (imem_rdata),
        .imem_error     (imem_error),
        .buf_depth      (buf_depth),
        .buf_next_depth (buf_next_depth),
        .flush          (flush),
        .store_word     (store_word),
        .store_upper    (store_upper),
        .in_data        (in_data),
        .in_error       (in_error)
    );

    // Head length flags are only needed inside the buffer
    fetch_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_buffer (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .flush       (flush),
        .store_word  (store_word),
        .store_upper (store_upper),
        .in_data     (in_data),
        .in_error    (in_error),
        .depth       (buf_depth),
        .next_depth  (buf_next_depth),
        .instr_is_16 (),
        .instr_is_32 (),
        .s1_busy     (s1_busy),
        .s1_valid    (s1_valid),
        .s1_data     (s1_data),
        .s1_error    (s1_error)
    );

endmodule

`default_nettype wire

//--- src.f
source/fetch_pkg.sv
source/fetch_buffer.sv
source/fetch_control.sv
source/fetch_unit.sv
sim/tb_fetch_mem.sv
sim/tb_fetch.sv
